// File: hw/stream_pkg.sv
package stream_pkg;

    // one data word of the input stream.
    typedef logic [15:0] word_t;

    // a beat carries one word and marks the end of its packet.
    typedef struct packed {
        word_t data;
        logic  last;
    } beat_t;

    // width of a beat when it travels as a plain vector.
    localparam int BEAT_WIDTH = $bits(beat_t);

endpackage

// File: hw/sum_pkg.sv
package sum_pkg;

    // running packet sum, wraps at 2**20.
    typedef logic [19:0] sum_t;

    // beat index within a packet, the first beat is 1.
    typedef logic [7:0] count_t;

    typedef struct packed {
        sum_t   sum;
        count_t count;
        logic   last;
    } sum_beat_t;

    localparam int SUM_BEAT_WIDTH = $bits(sum_beat_t);

endpackage

// File: hw/stream_flow.sv
`timescale 1ns/10ps

module stream_flow #(
    parameter int NUM_OUTPUTS = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    output logic [NUM_OUTPUTS-1:0] out_valid,
    input  logic [NUM_OUTPUTS-1:0] out_ready,
    output logic                   enable
);

    logic [NUM_OUTPUTS-1:0] valid_q;
    logic [NUM_OUTPUTS-1:0] slot_free;
    logic                   all_free;

    // a slot can take a new beat when it is empty or is handing its beat
    // over in this same cycle.
    assign slot_free = ~valid_q | out_ready;
    assign all_free  = &slot_free;

    assign in_ready  = all_free;
    assign enable    = in_valid & all_free;
    assign out_valid = valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < NUM_OUTPUTS; i++) begin
                if (enable) begin
                    valid_q[i] <= 1'b1;
                end else if (out_ready[i]) begin
                    // drained with nothing new behind it.
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/stream_stage.sv
`timescale 1ns/10ps

module stream_stage #(
    parameter int LATENCY = 1,
    parameter int WIDTH   = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    typedef logic [WIDTH-1:0] payload_t;

    generate
        if (LATENCY == 0) begin : g_bypass
            assign out_valid = in_valid;
            assign in_ready  = out_ready;
            assign out_data  = in_data;
        end else begin : g_pipe
            // link k feeds slot k, link LATENCY is the stage output.
            logic     [LATENCY:0] link_valid;
            logic     [LATENCY:0] link_ready;
            payload_t             link_data [LATENCY+1];

            assign link_valid[0] = in_valid;
            assign in_ready      = link_ready[0];
            assign link_data[0]  = in_data;

            assign out_valid           = link_valid[LATENCY];
            assign link_ready[LATENCY] = out_ready;
            assign out_data            = link_data[LATENCY];

            for (genvar k = 0; k < LATENCY; k++) begin : g_slot
                logic     enable;
                payload_t data_q;

                stream_flow #(
                    .NUM_OUTPUTS(1)
                ) u_flow (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .in_valid  (link_valid[k]),
                    .in_ready  (link_ready[k]),
                    .out_valid (link_valid[k+1]),
                    .out_ready (link_ready[k+1]),
                    .enable    (enable)
                );

                always_ff @(posedge clk) begin
                    if (enable) begin
                        data_q <= link_data[k];
                    end
                end

                assign link_data[k+1] = data_q;
            end
        end
    endgenerate

endmodule

// File: hw/stream_fork.sv
`timescale 1ns/10ps

module stream_fork (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  stream_pkg::beat_t in_beat,
    output logic              a_valid,
    input  logic              a_ready,
    output stream_pkg::beat_t a_beat,
    output logic              b_valid,
    input  logic              b_ready,
    output stream_pkg::beat_t b_beat
);

    import stream_pkg::*;

    logic       enable;
    logic [1:0] slot_valid;
    beat_t      a_q;
    beat_t      b_q;

    // slot 0 is output A, slot 1 is output B.
    stream_flow #(
        .NUM_OUTPUTS(2)
    ) u_flow (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (slot_valid),
        .out_ready ({b_ready, a_ready}),
        .enable    (enable)
    );

    always_ff @(posedge clk) begin
        if (enable) begin
            a_q <= in_beat;
            b_q <= in_beat;
        end
    end

    assign a_valid = slot_valid[0];
    assign a_beat  = a_q;
    assign b_valid = slot_valid[1];
    assign b_beat  = b_q;

endmodule

// File: hw/stream_accumulate.sv
`timescale 1ns/10ps

module stream_accumulate (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  stream_pkg::beat_t  in_beat,
    output logic               out_valid,
    input  logic               out_ready,
    output sum_pkg::sum_beat_t out_sum
);

    import stream_pkg::*;
    import sum_pkg::*;

    logic      enable;
    word_t     word;
    sum_t      sum_q;
    count_t    count_q;
    sum_t      next_sum;
    count_t    next_count;
    sum_beat_t out_q;

    stream_flow #(
        .NUM_OUTPUTS(1)
    ) u_flow (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .enable    (enable)
    );

    assign word       = in_beat.data;
    assign next_sum   = sum_q + sum_t'(word);
    assign next_count = count_q + count_t'(1);

    // running totals, cleared once the last beat of a packet goes through.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_q   <= '0;
            count_q <= '0;
        end else if (enable) begin
            sum_q   <= in_beat.last ? '0 : next_sum;
            count_q <= in_beat.last ? '0 : next_count;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            out_q <= '{sum: next_sum, count: next_count, last: in_beat.last};
        end
    end

    assign out_sum = out_q;

endmodule

// File: hw/stream_sum_top.sv
`timescale 1ns/10ps

module stream_sum_top #(
    parameter int LATENCY_IN  = 2,
    parameter int LATENCY_OUT = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  stream_pkg::beat_t  in_beat,
    output logic               a_valid,
    input  logic               a_ready,
    output stream_pkg::beat_t  a_beat,
    output logic               b_valid,
    input  logic               b_ready,
    output sum_pkg::sum_beat_t b_sum
);

    import stream_pkg::*;
    import sum_pkg::*;

    // input stage to fork.
    logic      stg_valid;
    logic      stg_ready;
    beat_t     stg_beat;

    // fork output B to accumulator.
    logic      fb_valid;
    logic      fb_ready;
    beat_t     fb_beat;

    // accumulator to output stage.
    logic      acc_valid;
    logic      acc_ready;
    sum_beat_t acc_sum;

    stream_stage #(
        .LATENCY (LATENCY_IN),
        .WIDTH   (BEAT_WIDTH)
    ) u_stage_in (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_beat),
        .out_valid (stg_valid),
        .out_ready (stg_ready),
        .out_data  (stg_beat)
    );

    stream_fork u_fork (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (stg_valid),
        .in_ready (stg_ready),
        .in_beat  (stg_beat),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .a_beat   (a_beat),
        .b_valid  (fb_valid),
        .b_ready  (fb_ready),
        .b_beat   (fb_beat)
    );

    stream_accumulate u_accumulate (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fb_valid),
        .in_ready  (fb_ready),
        .in_beat   (fb_beat),
        .out_valid (acc_valid),
        .out_ready (acc_ready),
        .out_sum   (acc_sum)
    );

    stream_stage #(
        .LATENCY (LATENCY_OUT),
        .WIDTH   (SUM_BEAT_WIDTH)
    ) u_stage_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (acc_valid),
        .in_ready  (acc_ready),
        .in_data   (acc_sum),
        .out_valid (b_valid),
        .out_ready (b_ready),
        .out_data  (b_sum)
    );

endmodule

// File: test/stream_sum_tb.sv
`timescale 1ns/10ps

module stream_sum_tb;

    import stream_pkg::*;
    import sum_pkg::*;

    localparam int LATENCY_IN     = 2;
    localparam int LATENCY_OUT    = 1;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_BEATS      = 18;
    // the table runs once at full rate and once with random stalls.
    localparam int TIMEOUT_CYCLES = 8 * 2 * NUM_BEATS + 100;

    typedef struct packed {
        word_t  word;
        logic   last;
        sum_t   sum;
        count_t count;
    } table_row_t;

    // word, last, expected running sum, expected beat count.
    table_row_t stim_table [NUM_BEATS] = '{
        '{16'h0005, 1'b1, 20'h00005, 8'd1},
        '{16'h1234, 1'b0, 20'h01234, 8'd1},
        '{16'h0FFF, 1'b1, 20'h02233, 8'd2},
        '{16'hFFFF, 1'b0, 20'h0FFFF, 8'd1},
        '{16'hFFFE, 1'b0, 20'h1FFFD, 8'd2},
        '{16'hFFFD, 1'b1, 20'h2FFFA, 8'd3},
        '{16'h0001, 1'b0, 20'h00001, 8'd1},
        '{16'h0002, 1'b0, 20'h00003, 8'd2},
        '{16'h0003, 1'b0, 20'h00006, 8'd3},
        '{16'h0004, 1'b1, 20'h0000A, 8'd4},
        '{16'hFFFF, 1'b0, 20'h0FFFF, 8'd1},
        '{16'hF000, 1'b0, 20'h1EFFF, 8'd2},
        '{16'h8000, 1'b0, 20'h26FFF, 8'd3},
        '{16'hFFF0, 1'b0, 20'h36FEF, 8'd4},
        '{16'h0010, 1'b1, 20'h36FFF, 8'd5},
        '{16'hABCD, 1'b0, 20'h0ABCD, 8'd1},
        '{16'h0000, 1'b0, 20'h0ABCD, 8'd2},
        '{16'h7FFF, 1'b1, 20'h12BCC, 8'd3}
    };

    logic      clk = 1'b0;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    beat_t     in_beat;
    logic      a_valid;
    logic      a_ready;
    beat_t     a_beat;
    logic      b_valid;
    logic      b_ready;
    sum_beat_t b_sum;

    beat_t       queue_a [$];
    sum_beat_t   queue_b [$];
    logic [15:0] lfsr_state     = 16'd40405;
    int          a_hold         = 0;
    int          b_hold         = 0;
    int          cycle_count    = 0;
    int          first_in_cycle = -1;
    logic        seen_a         = 1'b0;
    logic        seen_b         = 1'b0;

    stream_sum_top #(
        .LATENCY_IN  (LATENCY_IN),
        .LATENCY_OUT (LATENCY_OUT)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_beat  (in_beat),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .a_beat   (a_beat),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b_sum    (b_sum)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h/%b expected %h/%b",
                                $time, name, got.data, got.last, exp.data, exp.last));
        end
    endtask

    task automatic check_sum(input string name, input sum_beat_t got, input sum_beat_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h/%0d/%b expected %h/%0d/%b",
                                $time, name, got.sum, got.count, got.last,
                                exp.sum, exp.count, exp.last));
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    // mostly ready, with an occasional long stall that holds one output alone.
    task automatic pick_ready(inout int hold, output logic level);
        logic [7:0] r;
        take_bits(4, r);
        if (hold > 0) begin
            hold--;
            level = 1'b0;
        end else if (r[3:0] == 4'd0) begin
            hold  = 10;
            level = 1'b0;
        end else begin
            level = (r[1:0] != 2'd0);
        end
    endtask

    task automatic set_ready_levels(input logic stalls);
        if (stalls) begin
            pick_ready(a_hold, a_ready);
            pick_ready(b_hold, b_ready);
        end else begin
            a_ready = 1'b1;
            b_ready = 1'b1;
        end
    endtask

    task automatic push_expected(input table_row_t row);
        queue_a.push_back('{data: row.word, last: row.last});
        queue_b.push_back('{sum: row.sum, count: row.count, last: row.last});
    endtask

    task automatic run_table(input logic stalls);
        int         idx;
        int         gap;
        logic [7:0] r;
        idx = 0;
        gap = 0;
        while (idx < NUM_BEATS) begin
            @(negedge clk);
            set_ready_levels(stalls);
            if (gap > 0) begin
                in_valid = 1'b0;
                gap--;
            end else begin
                in_valid = 1'b1;
                in_beat  = '{data: stim_table[idx].word, last: stim_table[idx].last};
            end
            @(posedge clk);
            if (in_valid && in_ready) begin
                push_expected(stim_table[idx]);
                idx++;
                if (stalls) begin
                    take_bits(2, r);
                    gap = int'(r);
                end
            end else if (in_valid && !stalls) begin
                abort_run("in_ready fell while both outputs were ready");
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs(input logic stalls);
        while (queue_a.size() != 0 || queue_b.size() != 0) begin
            @(negedge clk);
            set_ready_levels(stalls);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the outputs did not deliver all expected beats in time");
        end else if (rst_n) begin
            if (in_valid && in_ready && first_in_cycle < 0) begin
                first_in_cycle = cycle_count;
            end
            if (a_valid && !seen_a) begin
                seen_a = 1'b1;
                check_latency("a_valid latency", cycle_count - first_in_cycle, LATENCY_IN + 1);
            end
            if (b_valid && !seen_b) begin
                seen_b = 1'b1;
                check_latency("b_valid latency", cycle_count - first_in_cycle,
                              LATENCY_IN + 2 + LATENCY_OUT);
            end
            if (a_valid && a_ready) begin
                if (queue_a.size() == 0) begin
                    abort_run("output A delivered a beat that was never sent");
                end else begin
                    check_beat("a_beat", a_beat, queue_a.pop_front());
                end
            end
            if (b_valid && b_ready) begin
                if (queue_b.size() == 0) begin
                    abort_run("output B delivered a sum that was never expected");
                end else begin
                    check_sum("b_sum", b_sum, queue_b.pop_front());
                end
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        a_ready  = 1'b1;
        b_ready  = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_flag("in_ready", in_ready, 1'b1);
        check_flag("a_valid", a_valid, 1'b0);
        check_flag("b_valid", b_valid, 1'b0);

        run_table(1'b0);
        drain_outputs(1'b0);
        run_table(1'b1);
        drain_outputs(1'b1);

        // a few quiet cycles with both outputs open catch any extra beat.
        @(negedge clk);
        set_ready_levels(1'b0);
        repeat (LATENCY_IN + LATENCY_OUT + 6) @(negedge clk);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sources.f
hw/stream_pkg.sv
hw/sum_pkg.sv
hw/stream_flow.sv
hw/stream_stage.sv
hw/stream_fork.sv
hw/stream_accumulate.sv
hw/stream_sum_top.sv
test/stream_sum_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module stream_sum_tb \
    -f sources.f -o sim_stream_sum
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_stream_sum
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
